// File: source/isaPkg.sv
`default_nettype none

package isaPkg;

   typedef logic [15:0] wordT;
   typedef logic signed [10:0] valueT;
   typedef logic [3:0] pcT;

   localparam valueT ValueMax = 11'sd999;
   localparam valueT ValueMin = -11'sd999;

   // Bit 14 clear marks a MOV word
   localparam int AluBit = 14;

   // Source field codes above the literal range
   localparam logic [10:0] SrcNil = 11'd1000;
   localparam logic [10:0] SrcAcc = 11'd1001;
   localparam logic [10:0] SrcLeft = 11'd1004;
   localparam logic [10:0] SrcRight = 11'd1005;
   localparam logic [10:0] SrcUp = 11'd1006;
   localparam logic [10:0] SrcDown = 11'd1007;

   // Class field, bits 13:11 of a non-MOV word
   localparam logic [2:0] ClassAdd = 3'b100;
   localparam logic [2:0] ClassSub = 3'b101;
   localparam logic [2:0] ClassJro = 3'b110;
   localparam logic [2:0] ClassMisc = 3'b111;

   // Subcode, bits 10:4 of the misc class
   localparam logic [6:0] SubJmp = 7'b1111010;
   localparam logic [6:0] SubJez = 7'b1111011;
   localparam logic [6:0] SubJnz = 7'b1111100;
   localparam logic [6:0] SubJgz = 7'b1111101;
   localparam logic [6:0] SubJlz = 7'b1111110;
   localparam logic [6:0] SubSpecial = 7'b1111111;

   // Low nibble of the special subcode
   localparam logic [3:0] MiscSwp = 4'b1100;
   localparam logic [3:0] MiscSav = 4'b1101;
   localparam logic [3:0] MiscNeg = 4'b1110;
   localparam logic [3:0] MiscNop = 4'b1111;

   typedef enum logic [2:0] {
      DestNil = 3'd0,
      DestAcc = 3'd1,
      DestLeft = 3'd4,
      DestRight = 3'd5,
      DestUp = 3'd6,
      DestDown = 3'd7
   } destT;

   typedef enum logic [3:0] {
      Mov, Add, Sub, Jro,
      Jmp, Jez, Jnz, Jgz, Jlz,
      Swp, Sav, Neg, Nop
   } opT;

   typedef struct packed {
      opT op;
      destT dest;
      pcT target; // Jump target slot
   } ctrlT;

   typedef struct packed {
      valueT value;
      logic ready; // Low while a source port is empty
   } operandT;

endpackage

`default_nettype wire

// File: source/nodePkg.sv
`default_nettype none

package nodePkg;

   // Low two bits of a port code
   typedef enum logic [1:0] {
      Left = 2'd0,
      Right = 2'd1,
      Up = 2'd2,
      Down = 2'd3
   } dirT;

   // Left in bit 0 so a dirT value indexes the flag
   typedef struct packed {
      logic down;
      logic up;
      logic right;
      logic left;
   } portFlagsT;

   typedef struct packed {
      isaPkg::valueT down;
      isaPkg::valueT up;
      isaPkg::valueT right;
      isaPkg::valueT left;
   } portValuesT;

endpackage

`default_nettype wire

// File: source/operandFetch.sv
`default_nettype none

module operandFetch (
   input  wire isaPkg::wordT         instr,
   input  wire isaPkg::valueT        acc,
   input  wire nodePkg::portFlagsT   rready,
   input  wire nodePkg::portValuesT  inValues,
   output isaPkg::operandT           operand,
   output nodePkg::portFlagsT        readSel
);

   import isaPkg::*;
   import nodePkg::*;

   logic [10:0] srcField;
   logic        usesSource;
   dirT         srcDir;
   valueT       portValue;
   logic        portReady;

   assign srcField = instr[10:0];
   assign srcDir = dirT'(srcField[1:0]); // 1004..1007 end in 00..11

   // Jumps and misc words carry no source
   assign usesSource = !instr[AluBit] ||
                       (instr[13:11] inside {ClassAdd, ClassSub, ClassJro});

   always_comb begin
      case (srcDir)
         Left: begin
            portValue = inValues.left;
            portReady = rready.left;
         end
         Right: begin
            portValue = inValues.right;
            portReady = rready.right;
         end
         Up: begin
            portValue = inValues.up;
            portReady = rready.up;
         end
         default: begin
            portValue = inValues.down;
            portReady = rready.down;
         end
      endcase
   end

   always_comb begin
      operand.value = '0;
      operand.ready = 1'b1;
      readSel = '0;
      if (usesSource) begin
         case (srcField)
            SrcNil: operand.value = '0;
            SrcAcc: operand.value = acc;
            SrcLeft, SrcRight, SrcUp, SrcDown: begin
               operand.value = portValue;
               operand.ready = portReady; // Stall until the neighbour has data
               readSel = portFlagsT'(4'(portReady) << srcDir);
            end
            default: begin
               // Codes 1002/1003 and up fall through as zero
               if (valueT'(srcField) <= ValueMax) begin
                  operand.value = valueT'(srcField);
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/instrDecode.sv
`default_nettype none

module instrDecode (
   input  wire isaPkg::wordT instr,
   output isaPkg::ctrlT      ctrl
);

   import isaPkg::*;

   logic [2:0] classField;
   logic [2:0] destField;
   logic [6:0] subField;

   assign classField = instr[13:11];
   assign destField = instr[13:11];
   assign subField = instr[10:4];

   always_comb begin
      ctrl.op = Nop;
      ctrl.dest = DestNil;
      ctrl.target = instr[3:0];

      if (!instr[AluBit]) begin
         ctrl.op = Mov;
         // ANY and LAST (2, 3) act as NIL
         if (destField[2] || destField == 3'd1) begin
            ctrl.dest = destT'(destField);
         end
      end else begin
         case (classField)
            ClassAdd: ctrl.op = Add;
            ClassSub: ctrl.op = Sub;
            ClassJro: ctrl.op = Jro;
            ClassMisc: begin
               case (subField)
                  SubJmp: ctrl.op = Jmp;
                  SubJez: ctrl.op = Jez;
                  SubJnz: ctrl.op = Jnz;
                  SubJgz: ctrl.op = Jgz;
                  SubJlz: ctrl.op = Jlz;
                  SubSpecial: begin
                     case (instr[3:0])
                        MiscSwp: ctrl.op = Swp;
                        MiscSav: ctrl.op = Sav;
                        MiscNeg: ctrl.op = Neg;
                        MiscNop: ctrl.op = Nop;
                        default: ctrl.op = Nop;
                     endcase
                  end
                  default: ctrl.op = Nop;
               endcase
            end
            default: ctrl.op = Nop; // Unused classes
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/execCore.sv
`default_nettype none

module execCore #(
   parameter int ProgDepth = 15
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire isaPkg::pcT          progLength,
   input  wire isaPkg::wordT        progWords [ProgDepth],
   input  wire isaPkg::ctrlT        ctrl,
   input  wire isaPkg::operandT     operand,
   input  wire nodePkg::portFlagsT  readSel,
   input  wire nodePkg::portFlagsT  wready,
   output isaPkg::wordT             instr,
   output isaPkg::valueT            out,
   output nodePkg::portFlagsT       write,
   output nodePkg::portFlagsT       read,
   output isaPkg::pcT               pc,
   output isaPkg::valueT            acc,
   output isaPkg::valueT            bak
);

   import isaPkg::*;
   import nodePkg::*;

   typedef enum logic {
      Run,
      WriteWait
   } nodeStateT;

   nodeStateT          state;
   pcT                 lastPc;
   pcT                 pcNext;
   pcT                 jroPc;
   logic signed [11:0] addSum;
   logic signed [11:0] subSum;
   logic signed [11:0] jroSum;
   logic               writeDone;
   dirT                wrDir;

   function automatic valueT saturate(input logic signed [11:0] sum);
      valueT result;
      if (sum > ValueMax) begin
         result = ValueMax;
      end else if (sum < ValueMin) begin
         result = ValueMin;
      end else begin
         result = valueT'(sum);
      end
      return result;
   endfunction

   // Slots past the array read as MOV 0, NIL
   assign instr = (pc < ProgDepth) ? progWords[pc] : '0;

   assign lastPc = progLength - 1'b1;
   assign pcNext = (pc >= lastPc) ? '0 : pc + 1'b1;

   assign addSum = acc + operand.value;
   assign subSum = acc - operand.value;
   assign jroSum = signed'({8'd0, pc}) + operand.value;

   assign writeDone = |(write & wready);
   assign wrDir = dirT'(ctrl.dest[1:0]);

   always_comb begin
      if (jroSum < 0) begin
         jroPc = '0;
      end else if (jroSum > signed'({8'd0, lastPc})) begin
         jroPc = lastPc;
      end else begin
         jroPc = pcT'(jroSum);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= Run;
         pc <= '0;
         acc <= '0;
         bak <= '0;
         out <= '0;
         write <= '0;
         read <= '0;
      end else begin
         read <= '0;
         if (progLength != '0) begin
            if (state == WriteWait) begin
               if (writeDone) begin // Neighbour took the value
                  write <= '0;
                  pc <= pcNext;
                  state <= Run;
               end
            end else if (operand.ready) begin
               read <= readSel;
               pc <= pcNext;
               case (ctrl.op)
                  Mov: begin
                     if (ctrl.dest == DestAcc) begin
                        acc <= operand.value;
                     end else if (ctrl.dest inside {DestLeft, DestRight, DestUp, DestDown}) begin
                        out <= operand.value;
                        write <= portFlagsT'(4'b0001 << wrDir);
                        pc <= pc; // Held until wready
                        state <= WriteWait;
                     end
                  end
                  Add: acc <= saturate(addSum);
                  Sub: acc <= saturate(subSum);
                  Jro: pc <= jroPc;
                  Jmp: pc <= ctrl.target;
                  Jez: if (acc == 0) pc <= ctrl.target;
                  Jnz: if (acc != 0) pc <= ctrl.target;
                  Jgz: if (acc > 0) pc <= ctrl.target;
                  Jlz: if (acc < 0) pc <= ctrl.target;
                  Swp: begin
                     acc <= bak;
                     bak <= acc;
                  end
                  Sav: bak <= acc;
                  Neg: acc <= -acc;
                  default: ;
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/tisNode.sv
`default_nettype none

module tisNode #(
   parameter int ProgDepth = 15
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire isaPkg::pcT          progLength,
   input  wire isaPkg::wordT        progWords [ProgDepth],
   input  wire nodePkg::portFlagsT  rready,
   input  wire nodePkg::portFlagsT  wready,
   input  wire nodePkg::portValuesT inValues,
   output isaPkg::valueT            out,
   output nodePkg::portFlagsT       write,
   output nodePkg::portFlagsT       read,
   output isaPkg::pcT               pc,
   output isaPkg::valueT            acc,
   output isaPkg::valueT            bak
);

   import isaPkg::*;
   import nodePkg::*;

   wordT      instr;
   ctrlT      ctrl;
   operandT   operand;
   portFlagsT readSel;

   operandFetch u_operandFetch (
      .instr    (instr),
      .acc      (acc),
      .rready   (rready),
      .inValues (inValues),
      .operand  (operand),
      .readSel  (readSel)
   );

   instrDecode u_instrDecode (
      .instr (instr),
      .ctrl  (ctrl)
   );

   execCore #(
      .ProgDepth (ProgDepth)
   ) u_execCore (
      .clk        (clk),
      .rst        (rst),
      .progLength (progLength),
      .progWords  (progWords),
      .ctrl       (ctrl),
      .operand    (operand),
      .readSel    (readSel),
      .wready     (wready),
      .instr      (instr),
      .out        (out),
      .write      (write),
      .read       (read),
      .pc         (pc),
      .acc        (acc),
      .bak        (bak)
   );

endmodule

`default_nettype wire

// File: testbench/tisNode_checker.sv
`default_nettype none

module tisNode_checker (
   input wire                     clk,
   input wire                     rst,
   input wire isaPkg::pcT         progLength,
   input wire isaPkg::pcT         pc,
   input wire isaPkg::valueT      out,
   input wire nodePkg::portFlagsT write,
   input wire nodePkg::portFlagsT read,
   input wire nodePkg::portFlagsT wready
);

   timeunit 1ns;
   timeprecision 100ps;

   writeOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(write))
      else $error("write has more than one bit set");

   readOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(read))
      else $error("read has more than one bit set");

   pcInRange: assert property (@(posedge clk) disable iff (rst)
      (progLength != 0) |-> (pc < progLength))
      else $error("pc beyond program length");

   // Back-pressure holds the write level and the value
   writeHeld: assert property (@(posedge clk) disable iff (rst)
      (|(write & ~wready)) |=> (write == $past(write)) && $stable(out))
      else $error("write dropped without wready");

endmodule

bind tisNode tisNode_checker u_checker (
   .clk        (clk),
   .rst        (rst),
   .progLength (progLength),
   .pc         (pc),
   .out        (out),
   .write      (write),
   .read       (read),
   .wready     (wready)
);

`default_nettype wire

// File: testbench/tisNodeTb.sv
`default_nettype none

module tisNodeTb;

   timeunit 1ns;
   timeprecision 100ps;

   import isaPkg::*;
   import nodePkg::*;

   localparam int Depth = 15;
   localparam int NumCases = 5;

   logic       clk = 1'b0;
   logic       rst;
   pcT         progLength;
   wordT       progWords [Depth];
   portFlagsT  rready;
   portFlagsT  wready;
   portValuesT inValues;
   valueT      out;
   portFlagsT  write;
   portFlagsT  read;
   pcT         pc;
   valueT      acc;
   valueT      bak;

   wordT  progTable [NumCases][Depth];
   pcT    lenTable [NumCases];
   int    cycleTable [NumCases];
   valueT accTable [NumCases];
   valueT bakTable [NumCases];
   pcT    pcTable [NumCases];

   int          mismatchCount = 0;
   int          timeoutCount = 0;
   logic [31:0] rngState = 32'h7125_6de8;

   always #2 clk = ~clk; // 4 ns period

   tisNode #(.ProgDepth(Depth)) u_tisNode (
      .clk(clk), .rst(rst), .progLength(progLength), .progWords(progWords),
      .rready(rready), .wready(wready), .inValues(inValues), .out(out),
      .write(write), .read(read), .pc(pc), .acc(acc), .bak(bak)
   );

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic valueT randomValue();
      return valueT'(int'(xorshift() % 1999) - 999); // Literal range only
   endfunction

   function automatic wordT encodeMov(destT d, int src);
      return {2'b00, d, 11'(src)};
   endfunction

   function automatic wordT encodeAlu(logic [2:0] cls, int src);
      return {2'b01, cls, 11'(src)};
   endfunction

   function automatic wordT encodeJump(logic [6:0] sub, int target);
      return {2'b01, ClassMisc, sub, 4'(target)};
   endfunction

   function automatic wordT encodeMisc(logic [3:0] misc);
      return {2'b01, ClassMisc, SubSpecial, misc};
   endfunction

   task automatic checkValue(string name, valueT got, valueT exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         mismatchCount++;
      end
   endtask

   task automatic checkPc(pcT got, pcT exp);
      if (got !== exp) begin
         $display("mismatch at %0t: pc got %0d expected %0d", $time, got, exp);
         mismatchCount++;
      end
   endtask

   task automatic checkFlags(string name, portFlagsT got, portFlagsT exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         mismatchCount++;
      end
   endtask

   // Loads a program and holds reset for three edges
   task automatic resetNode(pcT len, int row);
      @(posedge clk);
      rst <= 1'b1;
      progLength <= len;
      for (int k = 0; k < Depth; k++) begin
         progWords[k] <= (row >= 0) ? progTable[row][k] : encodeMisc(MiscNop);
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic setRow(int r, pcT len, int cycles, int a, int b, pcT p);
      lenTable[r] = len;
      cycleTable[r] = cycles;
      accTable[r] = valueT'(a);
      bakTable[r] = valueT'(b);
      pcTable[r] = p;
   endtask

   task automatic fillTable();
      for (int r = 0; r < NumCases; r++) begin
         for (int k = 0; k < Depth; k++) begin
            progTable[r][k] = encodeMisc(MiscNop);
         end
      end
      // Saturating arithmetic
      progTable[0][0] = encodeMov(DestAcc, 300);
      progTable[0][1] = encodeAlu(ClassAdd, SrcAcc);
      progTable[0][2] = encodeAlu(ClassAdd, 500);
      progTable[0][3] = encodeAlu(ClassSub, 999);
      progTable[0][4] = encodeAlu(ClassSub, 999);
      progTable[0][5] = encodeAlu(ClassSub, 5);
      setRow(0, 6, 6, -999, 0, 0);
      // Register moves
      progTable[1][0] = encodeMov(DestAcc, 12);
      progTable[1][1] = encodeMisc(MiscSav);
      progTable[1][2] = encodeMov(DestAcc, -7);
      progTable[1][3] = encodeMisc(MiscSwp);
      progTable[1][4] = encodeMisc(MiscNeg);
      setRow(1, 5, 5, -12, -7, 0);
      // Jumps taken and not taken
      progTable[2][0] = encodeJump(SubJez, 2);
      progTable[2][1] = encodeMov(DestAcc, 111);
      progTable[2][2] = encodeMov(DestAcc, 5);
      progTable[2][3] = encodeJump(SubJnz, 5);
      progTable[2][4] = encodeMov(DestAcc, 222);
      progTable[2][5] = encodeJump(SubJgz, 7);
      progTable[2][6] = encodeAlu(ClassAdd, 1);
      progTable[2][7] = encodeMisc(MiscNeg);
      progTable[2][8] = encodeJump(SubJlz, 10);
      progTable[2][9] = encodeAlu(ClassAdd, 1);
      progTable[2][10] = encodeJump(SubJgz, 12);
      progTable[2][11] = encodeMisc(MiscSav);
      progTable[2][12] = encodeJump(SubJmp, 0);
      setRow(2, 13, 9, -5, -5, 0);
      // JRO clamps at both ends
      progTable[3][0] = encodeAlu(ClassJro, 50);
      progTable[3][3] = encodeAlu(ClassJro, -50);
      setRow(3, 4, 3, 0, 0, 3);
      // Idle node
      progTable[4][0] = encodeMov(DestAcc, 77);
      progTable[4][1] = encodeMov(DestDown, 5);
      setRow(4, 0, 10, 0, 0, 0);
   endtask

   task automatic runTable();
      for (int r = 0; r < NumCases; r++) begin
         resetNode(lenTable[r], r);
         for (int c = 0; c < cycleTable[r]; c++) begin
            @(posedge clk);
            @(negedge clk);
            checkFlags("write", write, '0);
            checkFlags("read", read, '0);
         end
         checkValue("acc", acc, accTable[r]);
         checkValue("bak", bak, bakTable[r]);
         checkPc(pc, pcTable[r]);
      end
   endtask

   task automatic readStall();
      valueT v;
      int    waited;
      v = randomValue();
      for (int k = 0; k < Depth; k++) begin
         progTable[0][k] = encodeMisc(MiscNop);
      end
      progTable[0][0] = encodeMov(DestAcc, SrcLeft);
      progTable[0][1] = encodeAlu(ClassAdd, SrcLeft);
      resetNode(2, 0);
      repeat (5) begin
         @(negedge clk);
         checkPc(pc, 0);
         checkFlags("read", read, '0);
      end
      @(posedge clk);
      inValues.left <= v;
      rready.left <= 1'b1;
      @(posedge clk);
      rready.left <= 1'b0; // One value only
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!read.left && waited < 10);
      if (!read.left) begin
         $display("timeout: read.left never pulsed for the left port value");
         timeoutCount++;
      end
      checkValue("acc", acc, v);
      checkPc(pc, 1);
      @(negedge clk);
      checkFlags("read", read, '0);
      checkPc(pc, 1);
   endtask

   task automatic writeBackPressure();
      portFlagsT downFlag;
      portFlagsT upFlag;
      int        holdCycles;
      int        waited;
      downFlag = '0;
      downFlag.down = 1'b1;
      upFlag = '0;
      upFlag.up = 1'b1;
      holdCycles = 1 + int'(xorshift() % 8);
      for (int k = 0; k < Depth; k++) begin
         progTable[0][k] = encodeMisc(MiscNop);
      end
      progTable[0][0] = encodeMov(DestDown, 321);
      progTable[0][1] = encodeAlu(ClassJro, SrcUp);
      resetNode(3, 0);
      inValues.up <= 40;
      rready.up <= 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!write.down && waited < 10);
      if (!write.down) begin
         $display("timeout: write.down never rose for the MOV to DOWN");
         timeoutCount++;
      end
      for (int c = 0; c < holdCycles; c++) begin
         checkFlags("write", write, downFlag);
         checkValue("out", out, 321);
         checkPc(pc, 0);
         @(negedge clk);
      end
      @(posedge clk);
      wready.down <= 1'b1;
      @(posedge clk);
      wready.down <= 1'b0;
      @(negedge clk);
      checkFlags("write", write, '0);
      checkPc(pc, 1);
      @(negedge clk);
      checkPc(pc, 2); // 1 + 40 clamped to the last slot
      checkFlags("read", read, upFlag);
   endtask

   initial begin
      rst = 1'b1;
      progLength = '0;
      rready = '0;
      wready = '0;
      inValues = '0;
      for (int k = 0; k < Depth; k++) begin
         progWords[k] = '0;
      end
      fillTable();
      runTable();
      readStall();
      writeBackPressure();
      $display("mismatches %0d, timeouts %0d", mismatchCount, timeoutCount);
      if (mismatchCount == 0 && timeoutCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
source/isaPkg.sv
source/nodePkg.sv
source/operandFetch.sv
source/instrDecode.sv
source/execCore.sv
source/tisNode.sv
testbench/tisNode_checker.sv
testbench/tisNodeTb.sv

// File: Makefile
BIN = obj_dir/VtisNodeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wall -f all.f --top-module tisNodeTb -Mdir obj_dir

run: compile
	./$(BIN) | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
